//--- rv_core.f
logic/rv_pkg.sv
logic/inst_mem.sv
logic/insn_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/pc_unit.sv
logic/rv_core.sv
test/tb_clock.sv
test/rv_core_properties.sv
test/rv_core_tb.sv

//--- test/rv_core_trace.txt
// columns: kind, a, b (hex). kind 1 = program (word address, instruction),
// kind 2 = register write (index, value), kind 3 = halt (pc, unused)
// lui, auipc
1 00000000 800000B7
1 00000001 00001117
// register-immediate group
1 00000002 FFB00193
1 00000003 FFC1A213
1 00000004 0051B293
1 00000005 FFF1C313
1 00000006 7F036393
1 00000007 FF01F413
1 00000008 01F21493
1 00000009 01F0D513
1 0000000A 4011D593
1 0000000B 4000D613
// register-register group
1 0000000C 001086B3
1 0000000D 40400733
1 0000000E 0040A7B3
1 0000000F 0040B833
1 00000010 0061C8B3
1 00000011 00721933
1 00000012 0040D9B3
1 00000013 4040DA33
1 00000014 00656AB3
1 00000015 00747B33
// write to x0, then read it back
1 00000016 00520013
1 00000017 00400BB3
// branches, a skipped slot writes x31
1 00000018 00A20463
1 00000019 00100F93
1 0000001A 00A21463
1 0000001B 01800C13
1 0000001C 0040C463
1 0000001D 00100F93
1 0000001E 0040D463
1 0000001F 01900C93
1 00000020 0040E463
1 00000021 01A00D13
1 00000022 0040F463
1 00000023 00100F93
1 00000024 00125463
1 00000025 00100F93
1 00000026 00126463
1 00000027 00100F93
1 00000028 00124463
1 00000029 01B00D93
1 0000002A 00127463
1 0000002B 01C00E13
1 0000002C 00120463
1 0000002D 01D00E93
// counted loop of three, then ecall
1 0000002E 00300F13
1 0000002F FFFF0F13
1 00000030 FE0F1EE3
1 00000031 00000073
// expected writes in program order
2 00000001 80000000
2 00000002 00001004
2 00000003 FFFFFFFB
2 00000004 00000001
2 00000005 00000000
2 00000006 00000004
2 00000007 000007F4
2 00000008 FFFFFFF0
2 00000009 80000000
2 0000000A 00000001
2 0000000B FFFFFFFD
2 0000000C 80000000
2 0000000D 00000000
2 0000000E FFFFFFFF
2 0000000F 00000001
2 00000010 00000000
2 00000011 FFFFFFFF
2 00000012 00100000
2 00000013 40000000
2 00000014 C0000000
2 00000015 00000005
2 00000016 000007F0
2 00000000 00000006
2 00000017 00000001
2 00000018 00000018
2 00000019 00000019
2 0000001A 0000001A
2 0000001B 0000001B
2 0000001C 0000001C
2 0000001D 0000001D
2 0000001E 00000003
2 0000001E 00000002
2 0000001E 00000001
2 0000001E 00000000
3 000000C4 00000000

//--- test/rv_core_tb.sv
module rv_core_tb;

  localparam int IMEM_WORDS   = 256;
  localparam int RESET_CYCLES = 10;
  localparam int HALT_CYCLES  = 20;
  localparam int MAX_RECORDS  = 128;

  // record kinds in the trace
  localparam logic [31:0] REC_PROG  = 32'd1;
  localparam logic [31:0] REC_WRITE = 32'd2;
  localparam logic [31:0] REC_HALT  = 32'd3;

  logic             clk;
  logic             rst;
  logic             i_run;
  logic             i_load_we;
  rv_pkg::word_t    i_load_addr;
  rv_pkg::word_t    i_load_data;
  rv_pkg::word_t    o_pc;
  logic             o_halt;
  logic             o_wb_valid;
  rv_pkg::reg_idx_t o_wb_rd;
  rv_pkg::word_t    o_wb_data;

  logic [31:0]      trace_mem [3*MAX_RECORDS];
  rv_pkg::word_t    prog_addr [$];
  rv_pkg::word_t    prog_data [$];
  rv_pkg::reg_idx_t exp_rd [$];
  rv_pkg::word_t    exp_data [$];
  rv_pkg::word_t    exp_halt_pc;
  int               halt_lines;
  int               watchdog_cycles;
  int               errors;
  int               checks;
  int               wb_seen;

  tb_clock #(
    .PERIOD(100)
  ) clk_gen_i (
    .o_clk(clk)
  );

  rv_core #(
    .IMEM_WORDS(IMEM_WORDS)
  ) dut_i (
    .clk        (clk),
    .rst        (rst),
    .i_run      (i_run),
    .i_load_we  (i_load_we),
    .i_load_addr(i_load_addr),
    .i_load_data(i_load_data),
    .o_pc       (o_pc),
    .o_halt     (o_halt),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data)
  );

  task automatic check_reg(input string name, input rv_pkg::reg_idx_t exp,
                           input rv_pkg::reg_idx_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s expected=x%0d actual=x%0d", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t exp,
                            input rv_pkg::word_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s expected=%h actual=%h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s expected=%b actual=%b", name, exp, act);
    end
  endtask

  // three words per record, a zero kind ends the list
  task automatic read_trace();
    int          rec;
    logic [31:0] kind;
    for (int n = 0; n < 3 * MAX_RECORDS; n++)
    begin
      trace_mem[n] = '0;
    end
    $readmemh("test/rv_core_trace.txt", trace_mem);
    rec = 0;
    while (rec < MAX_RECORDS && trace_mem[3*rec] != 32'd0)
    begin
      kind = trace_mem[3*rec];
      case (kind)
        REC_PROG:
        begin
          prog_addr.push_back(trace_mem[3*rec+1]);
          prog_data.push_back(trace_mem[3*rec+2]);
        end
        REC_WRITE:
        begin
          exp_rd.push_back(trace_mem[3*rec+1][4:0]);
          exp_data.push_back(trace_mem[3*rec+2]);
        end
        REC_HALT:
        begin
          exp_halt_pc = trace_mem[3*rec+1];
          halt_lines++;
        end
        default:
        begin
          errors++;
          $display("ERROR: trace record %0d has an unknown kind %h", rec, kind);
        end
      endcase
      rec++;
    end
    if (prog_addr.size() == 0 || halt_lines != 1)
    begin
      errors++;
      $display("ERROR: trace needs a program and exactly one halt line");
    end
  endtask

  // one word per clock through the load port
  task automatic load_program();
    for (int k = 0; k < prog_addr.size(); k++)
    begin
      i_load_we   <= 1'b1;
      i_load_addr <= prog_addr[k];
      i_load_data <= prog_data[k];
      @(posedge clk);
    end
    i_load_we <= 1'b0;
  endtask

  // outputs are sampled before the edge updates the core
  always @(posedge clk)
  begin
    if (o_wb_valid === 1'b1)
    begin
      if (exp_rd.size() == 0)
      begin
        errors++;
        $display("ERROR: unexpected write of %h to x%0d after the last expected write",
                 o_wb_data, o_wb_rd);
      end
      else
      begin
        check_reg($sformatf("write %0d rd", wb_seen), exp_rd.pop_front(), o_wb_rd);
        check_word($sformatf("write %0d data", wb_seen), exp_data.pop_front(), o_wb_data);
      end
      wb_seen++;
    end
  end

  initial
  begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("ERROR: the core never halted within %0d cycles", watchdog_cycles);
    $display("errors=%0d checks=%0d writes=%0d", errors + 1, checks, wb_seen);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    rst         = 1'b1;
    i_run       = 1'b0;
    i_load_we   = 1'b0;
    i_load_addr = '0;
    i_load_data = '0;
    errors      = 0;
    checks      = 0;
    wb_seen     = 0;
    halt_lines  = 0;
    read_trace();
    watchdog_cycles = 10 * exp_rd.size() + 8 * prog_addr.size() + 50;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    load_program();
    i_run <= 1'b1;

    @(posedge clk);
    while (o_halt !== 1'b1)
    begin
      @(posedge clk);
    end
    check_word("halt pc", exp_halt_pc, o_pc);

    // core must stay parked on the ecall
    repeat (HALT_CYCLES) @(posedge clk);
    check_word("pc held after halt", exp_halt_pc, o_pc);
    check_flag("halt held", 1'b1, o_halt);
    if (exp_rd.size() != 0)
    begin
      errors++;
      $display("ERROR: %0d expected register writes never appeared", exp_rd.size());
    end

    $display("errors=%0d checks=%0d writes=%0d", errors, checks, wb_seen);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- test/rv_core_properties.sv
module rv_core_properties (
  input logic          clk,
  input logic          rst,
  input logic          i_run,
  input rv_pkg::word_t o_pc,
  input logic          o_halt,
  input logic          o_wb_valid
);

  // instructions are 4 bytes, nothing jumps to a half word
  pc_aligned: assert property (@(posedge clk) disable iff (rst) o_pc[1:0] == 2'b00)
    else $error("pc is not word aligned: %h", o_pc);

  wb_needs_run: assert property (@(posedge clk) disable iff (rst) !i_run |-> !o_wb_valid)
    else $error("write-back valid while the core is not running");

  halt_holds_pc: assert property (@(posedge clk) disable iff (rst)
                                  (o_halt && i_run) |=> $stable(o_pc))
    else $error("pc moved while halted");

  // synchronous reset clears the pc on the edge
  pc_after_reset: assert property (@(posedge clk) rst |=> o_pc == '0)
    else $error("pc not zero after reset: %h", o_pc);

endmodule

bind rv_core rv_core_properties props_i (.*);

//--- test/tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic o_clk
);

  initial
  begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

endmodule

//--- logic/rv_core.sv
module rv_core #(
  parameter int IMEM_WORDS = 256
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_run,
  input  logic             i_load_we,
  input  rv_pkg::word_t    i_load_addr,
  input  rv_pkg::word_t    i_load_data,
  output rv_pkg::word_t    o_pc,
  output logic             o_halt,
  output logic             o_wb_valid,
  output rv_pkg::reg_idx_t o_wb_rd,
  output rv_pkg::word_t    o_wb_data
);

  rv_pkg::insn_t    insn;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::word_t    imm;
  logic             use_imm;
  rv_pkg::alu_op_t  alu_op;
  logic             is_lui;
  logic             is_auipc;
  logic             is_branch;
  logic             reg_we;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_a;
  rv_pkg::word_t    alu_b;
  rv_pkg::word_t    alu_result;

  inst_mem #(
    .IMEM_WORDS(IMEM_WORDS)
  ) imem_i (
    .clk        (clk),
    .i_load_we  (i_load_we),
    .i_load_addr(i_load_addr),
    .i_load_data(i_load_data),
    .i_pc       (o_pc),
    .o_insn     (insn)
  );

  insn_decoder dec_i (
    .i_insn     (insn),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_wb_rd),
    .o_imm      (imm),
    .o_use_imm  (use_imm),
    .o_alu_op   (alu_op),
    .o_is_lui   (is_lui),
    .o_is_auipc (is_auipc),
    .o_is_branch(is_branch),
    .o_reg_we   (reg_we),
    .o_halt     (o_halt)
  );

  // x0 writes still show on the port, the file drops them
  assign o_wb_valid = reg_we && i_run && !o_halt;

  reg_file rf_i (
    .clk       (clk),
    .rst       (rst),
    .i_we      (o_wb_valid),
    .i_rd      (o_wb_rd),
    .i_rd_data (o_wb_data),
    .i_rs1     (rs1),
    .i_rs2     (rs2),
    .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data)
  );

  // operand muxes
  assign alu_a = is_auipc ? o_pc : rs1_data;
  assign alu_b = use_imm ? imm : rs2_data;

  alu alu_i (
    .i_a     (alu_a),
    .i_b     (alu_b),
    .i_op    (alu_op),
    .o_result(alu_result)
  );

  assign o_wb_data = is_lui ? imm : alu_result;

  pc_unit pc_i (
    .clk        (clk),
    .rst        (rst),
    .i_run      (i_run),
    .i_halt     (o_halt),
    .i_is_branch(is_branch),
    .i_insn     (insn),
    .i_imm      (imm),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_pc       (o_pc)
  );

endmodule

//--- logic/pc_unit.sv
module pc_unit (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_run,
  input  logic          i_halt,
  input  logic          i_is_branch,
  input  rv_pkg::insn_t i_insn,
  input  rv_pkg::word_t i_imm,
  input  rv_pkg::word_t i_rs1_data,
  input  rv_pkg::word_t i_rs2_data,
  output rv_pkg::word_t o_pc
);

  logic          is_eq;
  logic          is_lt;
  logic          is_ltu;
  logic          cond;
  rv_pkg::word_t pc_next;

  // branch comparator
  assign is_eq  = (i_rs1_data == i_rs2_data);
  assign is_lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign is_ltu = (i_rs1_data < i_rs2_data);

  always_comb
  begin
    case (i_insn.b.funct3)
      rv_pkg::F3_BEQ:  cond = is_eq;
      rv_pkg::F3_BNE:  cond = !is_eq;
      rv_pkg::F3_BLT:  cond = is_lt;
      rv_pkg::F3_BGE:  cond = !is_lt;
      rv_pkg::F3_BLTU: cond = is_ltu;
      rv_pkg::F3_BGEU: cond = !is_ltu;
      default:         cond = 1'b0;
    endcase
  end

  assign pc_next = (i_is_branch && cond) ? o_pc + i_imm : o_pc + 32'd4;

  // pc only moves while running and not halted
  always_ff @(posedge clk)
  begin
    if (rst)
      o_pc <= '0;
    else if (i_run && !i_halt)
      o_pc <= pc_next;
  end

endmodule

//--- logic/reg_file.sv
module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_we,
  input  rv_pkg::reg_idx_t i_rd,
  input  rv_pkg::word_t    i_rd_data,
  input  rv_pkg::reg_idx_t i_rs1,
  input  rv_pkg::reg_idx_t i_rs2,
  output rv_pkg::word_t    o_rs1_data,
  output rv_pkg::word_t    o_rs2_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:31];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (i_we && i_rd != 5'd0)
    begin
      regs[i_rd] <= i_rd_data;
    end
  end

  assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

//--- logic/alu.sv
module alu (
  input  rv_pkg::word_t   i_a,
  input  rv_pkg::word_t   i_b,
  input  rv_pkg::alu_op_t i_op,
  output rv_pkg::word_t   o_result
);

  logic [4:0] shamt;

  // shifts only look at the low 5 bits
  assign shamt = i_b[4:0];

  always_comb
  begin
    case (i_op)
      rv_pkg::ALU_ADD:
        o_result = i_a + i_b;
      rv_pkg::ALU_SUB:
        o_result = i_a - i_b;
      rv_pkg::ALU_SLL:
        o_result = i_a << shamt;
      rv_pkg::ALU_SLT:
        o_result = ($signed(i_a) < $signed(i_b)) ? 32'd1 : 32'd0;
      rv_pkg::ALU_SLTU:
        o_result = (i_a < i_b) ? 32'd1 : 32'd0;
      rv_pkg::ALU_XOR:
        o_result = i_a ^ i_b;
      rv_pkg::ALU_SRL:
        o_result = i_a >> shamt;
      rv_pkg::ALU_SRA:
        // arithmetic shift keeps the sign
        o_result = $signed(i_a) >>> shamt;
      rv_pkg::ALU_OR:
        o_result = i_a | i_b;
      rv_pkg::ALU_AND:
        o_result = i_a & i_b;
      default:
        o_result = '0;
    endcase
  end

endmodule

//--- logic/insn_decoder.sv
module insn_decoder (
  input  rv_pkg::insn_t    i_insn,
  output rv_pkg::reg_idx_t o_rs1,
  output rv_pkg::reg_idx_t o_rs2,
  output rv_pkg::reg_idx_t o_rd,
  output rv_pkg::word_t    o_imm,
  output logic             o_use_imm,
  output rv_pkg::alu_op_t  o_alu_op,
  output logic             o_is_lui,
  output logic             o_is_auipc,
  output logic             o_is_branch,
  output logic             o_reg_we,
  output logic             o_halt
);

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::alu_op_t group_op;
  logic          is_alt;

  assign o_rs1 = i_insn.r.rs1;
  assign o_rs2 = i_insn.r.rs2;
  assign o_rd  = i_insn.r.rd;

  // sign-extended immediates
  assign imm_i = {{20{i_insn.i.imm[11]}}, i_insn.i.imm};
  assign imm_b = {{19{i_insn.b.imm12}}, i_insn.b.imm12, i_insn.b.imm11,
                  i_insn.b.imm10_5, i_insn.b.imm4_1, 1'b0};
  assign imm_u = {i_insn.u.imm, 12'b0};

  // for immediates funct7 sits in imm[11:5]
  assign is_alt = (i_insn.r.funct7 == rv_pkg::FUNCT7_ALT);

  // operation shared by both alu groups
  always_comb
  begin
    case (i_insn.r.funct3)
      rv_pkg::F3_ADD_SUB:
      begin
        // no subi, so alt only counts for reg-reg
        if (is_alt && i_insn.r.opcode == rv_pkg::OP_REG_REG)
          group_op = rv_pkg::ALU_SUB;
        else
          group_op = rv_pkg::ALU_ADD;
      end
      rv_pkg::F3_SLL:  group_op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  group_op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: group_op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  group_op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SRL_SRA:
      begin
        group_op = is_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      end
      rv_pkg::F3_OR:   group_op = rv_pkg::ALU_OR;
      default:         group_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb
  begin
    o_imm       = imm_i;
    o_use_imm   = 1'b0;
    o_alu_op    = rv_pkg::ALU_ADD;
    o_is_lui    = 1'b0;
    o_is_auipc  = 1'b0;
    o_is_branch = 1'b0;
    o_reg_we    = 1'b0;
    o_halt      = 1'b0;
    case (i_insn.r.opcode)
      rv_pkg::OP_LUI:
      begin
        o_imm    = imm_u;
        o_is_lui = 1'b1;
        o_reg_we = 1'b1;
      end
      rv_pkg::OP_AUIPC:
      begin
        // pc + upper immediate through the adder
        o_imm      = imm_u;
        o_use_imm  = 1'b1;
        o_is_auipc = 1'b1;
        o_reg_we   = 1'b1;
      end
      rv_pkg::OP_REG_IMM:
      begin
        o_use_imm = 1'b1;
        o_alu_op  = group_op;
        o_reg_we  = 1'b1;
      end
      rv_pkg::OP_REG_REG:
      begin
        o_alu_op = group_op;
        o_reg_we = 1'b1;
      end
      rv_pkg::OP_BRANCH:
      begin
        o_imm       = imm_b;
        o_is_branch = 1'b1;
      end
      rv_pkg::OP_ENVIRON:
      begin
        // only ecall, every other field zero
        o_halt = (i_insn.i.imm == 12'd0) && (i_insn.i.rs1 == 5'd0) &&
                 (i_insn.i.funct3 == 3'd0) && (i_insn.i.rd == 5'd0);
      end
      default:
      begin
        // unknown opcode runs as a no-op
        o_reg_we = 1'b0;
      end
    endcase
  end

endmodule

//--- logic/inst_mem.sv
module inst_mem #(
  parameter int IMEM_WORDS = 256
) (
  input  logic          clk,
  input  logic          i_load_we,
  input  rv_pkg::word_t i_load_addr,
  input  rv_pkg::word_t i_load_data,
  input  rv_pkg::word_t i_pc,
  output rv_pkg::word_t o_insn
);

  localparam int ADDR_W = $clog2(IMEM_WORDS);

  rv_pkg::word_t mem [IMEM_WORDS];

  // load port takes word addresses
  always_ff @(posedge clk)
  begin
    if (i_load_we)
    begin
      mem[i_load_addr[ADDR_W-1:0]] <= i_load_data;
    end
  end

  // pc is a byte address, drop the low two bits and wrap
  assign o_insn = mem[i_pc[ADDR_W+1:2]];

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

  // register and word width
  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // major opcodes
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;
  localparam logic [6:0] OP_REG_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG_REG = 7'b0110011;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_ENVIRON = 7'b1110011;

  // funct3 for the two alu groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } i;
    // branch offset bits are scattered over the word
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } u;
  } insn_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

endpackage
